/* verilog.f */
logic/spr_pkg.sv
logic/intr_pkg.sv
logic/spr_access.sv
logic/int_sampler.sv
logic/interval_timer.sv
logic/int_controller.sv
logic/vector_issue.sv
logic/upd_periph_top.sv
dv/tb_upd_periph.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_upd_periph
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_upd_periph.sv */
`default_nettype none

module tb_upd_periph;
  timeunit 1ns;
  timeprecision 100ps;

  import spr_pkg::*;
  import intr_pkg::*;

  logic       CLK;
  logic       rst_n;
  spr_req_t   spr_req;
  logic [7:0] rd_data;
  logic       int0, int1, int2;
  logic [7:0] pa_out;
  logic [7:0] pb_in, pb_out, pb_oe;
  logic [7:0] pc_in, pc_out, pc_oe;
  int_vec_t   vec;
  logic       credit_return = 1'b0;

  // Consumer state
  int_vec_t    vec_log[$];
  int          outstanding = 0;
  logic        auto_ret = 1'b1;
  int          val_errs = 0;
  int          other_errs = 0;
  logic [31:0] lfsr_state = 32'd88993;

  upd_periph_top dut (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .spr_req       (spr_req),
    .rd_data       (rd_data),
    .int0          (int0),
    .int1          (int1),
    .int2          (int2),
    .pa_out        (pa_out),
    .pb_in         (pb_in),
    .pb_out        (pb_out),
    .pb_oe         (pb_oe),
    .pc_in         (pc_in),
    .pc_out        (pc_out),
    .pc_oe         (pc_oe),
    .vec           (vec),
    .credit_return (credit_return)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference model

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
    return v;
  endfunction

  // Mode bit set means input
  // PC6..PC2 always drive
  function automatic logic [7:0] exp_oe(input logic port_c, input logic [7:0] mode);
    logic [7:0] oe;
    for (int i = 0; i < 8; i++) begin
      oe[i] = !mode[i] || (port_c && i >= 2 && i <= 6);
    end
    return oe;
  endfunction

  function automatic logic [7:0] exp_pc_out(input logic [7:0] mc, input logic [7:0] latch);
    logic [7:0] v;
    for (int i = 0; i < 8; i++) begin
      v[i] = latch[i] & ((i >= 2) ? mc[i] : !mc[i]);
    end
    return v;
  endfunction

  function automatic logic [7:0] exp_port_read(input logic port_c, input logic [7:0] mode,
                                               input logic [7:0] latch, input logic [7:0] pins);
    logic [7:0] oe;
    logic [7:0] v;
    oe = exp_oe(port_c, mode);
    for (int i = 0; i < 8; i++) begin
      v[i] = oe[i] ? latch[i] : pins[i];
    end
    return v;
  endfunction

  function automatic logic [7:0] exp_vec_addr(input int_src_e src);
    case (src)
      INT_SRC_INT0: return 8'h04;
      INT_SRC_INTT: return 8'h08;
      INT_SRC_INT1: return 8'h10;
      default:      return 8'h20;
    endcase
  endfunction

  function automatic int_vec_t make_vec(input int_src_e src, input logic [7:0] addr);
    int_vec_t v;
    v.valid = 1'b1;
    v.src   = src;
    v.addr  = addr;
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_vec(input string name, input int_vec_t got, input int_vec_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_src(input string name, input int_src_e got, input int_src_e exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    other_errs++;
  endtask

  ////////////////////////////////////////////////////////////
  // Register port and waits

  task automatic write_spr(input spr_addr_e addr, input logic [7:0] data);
    @(negedge CLK);
    spr_req.wr    = 1'b1;
    spr_req.addr  = addr;
    spr_req.wdata = data;
    @(negedge CLK);
    spr_req.wr = 1'b0;
  endtask

  task automatic verify_read(input string name, input spr_addr_e addr, input logic [7:0] exp);
    @(negedge CLK);
    spr_req.rd   = 1'b1;
    spr_req.addr = addr;
    @(negedge CLK);
    spr_req.rd = 1'b0;
    check_byte(name, rd_data, exp);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge CLK);
  endtask

  task automatic wait_vecs(input int count, input int limit, input string what);
    int n;
    n = 0;
    while (vec_log.size() < count && n < limit) begin
      @(posedge CLK);
      n++;
    end
    if (vec_log.size() < count) begin
      report_error({"timeout waiting for ", what});
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (outstanding != 0 && n < limit) begin
      @(posedge CLK);
      n++;
    end
    if (outstanding != 0) begin
      report_error("timeout waiting for credits to drain");
    end
  endtask

  // Logs every vector and hands credits back one per cycle
  always @(negedge CLK) begin
    if (rst_n) begin
      if (vec.valid) begin
        vec_log.push_back(vec);
        check_byte("vec.addr", vec.addr, exp_vec_addr(vec.src));
        outstanding++;
      end
      if (auto_ret && outstanding > 0) begin
        credit_return = 1'b1;
        outstanding--;
      end else begin
        credit_return = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    logic [7:0] mb_v, mc_v, pa_v, pb_v, pc_v, pbp_v, pcp_v;
    logic [7:0] tm_n;
    int         base;
    int         hits;
    rst_n   = 1'b0;
    spr_req = '0;
    int0    = 1'b0;
    int1    = 1'b0;
    int2    = 1'b0;
    pb_in   = '0;
    pc_in   = '0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;

    // Reset values
    check_byte("rd_data", rd_data, 8'h00);
    verify_read("MK", SPR_MK, 8'hff);
    verify_read("MB", SPR_MB, 8'hff);
    verify_read("MC", SPR_MC, 8'hff);
    verify_read("PA", SPR_PA, 8'h00);
    verify_read("PB", SPR_PB, 8'h00);
    verify_read("PC", SPR_PC, 8'h00);
    check_byte("pb_oe", pb_oe, 8'h00);
    check_byte("pc_oe", pc_oe, exp_oe(1'b1, 8'hff));
    if (vec_log.size() != 0) report_error("vector issued after reset");

    // Port modes, latches and pin readback
    for (int k = 0; k < 16; k++) begin
      mb_v  = rand_bits(8);
      mc_v  = rand_bits(8);
      pa_v  = rand_bits(8);
      pb_v  = rand_bits(8);
      pc_v  = rand_bits(8);
      pbp_v = rand_bits(8);
      pcp_v = rand_bits(8);
      write_spr(SPR_MB, mb_v);
      write_spr(SPR_MC, mc_v);
      write_spr(SPR_PA, pa_v);
      write_spr(SPR_PB, pb_v);
      write_spr(SPR_PC, pc_v);
      @(negedge CLK);
      pb_in = pbp_v;
      pc_in = pcp_v;
      verify_read("PB", SPR_PB, exp_port_read(1'b0, mb_v, pb_v, pbp_v));
      verify_read("PC", SPR_PC, exp_port_read(1'b1, mc_v, pc_v, pcp_v));
      verify_read("MC", SPR_MC, mc_v);
      check_byte("pa_out", pa_out, pa_v);
      check_byte("pb_out", pb_out, pb_v);
      check_byte("pb_oe", pb_oe, exp_oe(1'b0, mb_v));
      check_byte("pc_oe", pc_oe, exp_oe(1'b1, mc_v));
      check_byte("pc_out", pc_out, exp_pc_out(mc_v, pc_v));
    end

    // Last read value stays while another register is written
    write_spr(SPR_MK, 8'hfb);
    check_byte("rd_data", rd_data, mc_v);

    // INT1 filter rejects two high ticks
    base = vec_log.size();
    idle(60);
    @(negedge CLK);
    int1 = 1'b1;
    repeat (24) @(negedge CLK);
    int1 = 1'b0;
    idle(100);
    if (vec_log.size() != base) report_error("INT1 high for two ticks gave a vector");
    @(negedge CLK);
    int1 = 1'b1;
    repeat (36) @(negedge CLK);
    int1 = 1'b0;
    wait_vecs(base + 1, 100, "INT1 vector");
    idle(100);
    if (vec_log.size() != base + 1) begin
      report_error("INT1 filter gave a wrong number of vectors");
    end else begin
      check_vec("vec INT1", vec_log[base], make_vec(INT_SRC_INT1, 8'h10));
    end

    // Falling INT2 after a polarity change that no tick sees
    write_spr(SPR_MK, 8'hdf);
    int2 = 1'b1;
    write_spr(SPR_MK, 8'hd7);
    base = vec_log.size();
    idle(100);
    if (vec_log.size() != base) report_error("INT2 polarity change gave a vector");
    @(negedge CLK);
    int2 = 1'b0;
    wait_vecs(base + 1, 100, "INT2 vector");
    idle(60);
    if (vec_log.size() != base + 1) begin
      report_error("falling INT2 gave a wrong number of vectors");
    end else begin
      check_vec("vec INT2", vec_log[base], make_vec(INT_SRC_INT2, 8'h20));
    end

    // Interval timer takes the new reload at the first underflow
    tm_n = 8'd3 + rand_bits(2);
    write_spr(SPR_TM0, tm_n);
    write_spr(SPR_TM1, 8'h00);
    verify_read("TM0", SPR_TM0, tm_n);
    write_spr(SPR_MK, 8'hfd);
    base = vec_log.size();
    wait_vecs(base + 1, 40000, "first timer vector");
    base = vec_log.size();
    idle(10 * (tm_n + 1) * 8);
    hits = 0;
    for (int i = base; i < vec_log.size(); i++) begin
      if (vec_log[i].addr == 8'h08) hits++;
    end
    if (hits < 9 || hits > 11) report_error("timer vector count outside 10 +/- 1");
    if (hits != vec_log.size() - base) report_error("non-timer vector during timer window");
    write_spr(SPR_MK, 8'hff);
    idle(20);

    // Priority and credits with sources pending while masked
    wait_drained(100);
    auto_ret = 1'b0;
    @(negedge CLK);
    int0 = 1'b1;
    int1 = 1'b1;
    int2 = 1'b1;
    idle(72);
    base = vec_log.size();
    write_spr(SPR_MK, 8'hf2);
    // INT0 re-arms while high, so it drops before the second grant
    int0 = 1'b0;
    wait_vecs(base + INT_CREDITS, 100, "vectors on the credit pool");
    idle(200);
    if (vec_log.size() != base + INT_CREDITS) begin
      report_error("vector count wrong while credits withheld");
    end else begin
      check_vec("vec INT0", vec_log[base], make_vec(INT_SRC_INT0, 8'h04));
      check_src("second src", vec_log[base + 1].src, INT_SRC_INT1);
    end
    auto_ret = 1'b1;
    wait_vecs(base + INT_CREDITS + 1, 100, "INT2 vector after credit return");
    idle(200);
    if (vec_log.size() != base + INT_CREDITS + 1) begin
      report_error("extra vector after credit return, masked source issued");
    end else begin
      check_vec("vec INT2", vec_log[base + INT_CREDITS], make_vec(INT_SRC_INT2, 8'h20));
    end
    wait_drained(100);

    $display("Summary: %0d value mismatches, %0d other errors, %0d vectors seen",
             val_errs, other_errs, vec_log.size());
    if (val_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/upd_periph_top.sv */
`default_nettype none

module upd_periph_top (
  input  logic               CLK,
  input  logic               rst_n,
  input  spr_pkg::spr_req_t  spr_req,
  output logic [7:0]         rd_data,
  input  logic               int0,
  input  logic               int1,
  input  logic               int2,
  output logic [7:0]         pa_out,
  input  logic [7:0]         pb_in,
  output logic [7:0]         pb_out,
  output logic [7:0]         pb_oe,
  input  logic [7:0]         pc_in,
  output logic [7:0]         pc_out,
  output logic [7:0]         pc_oe,
  output intr_pkg::int_vec_t vec,
  input  logic               credit_return
);
  import spr_pkg::*;
  import intr_pkg::*;

  logic [SPR_DATA_W-1:0] mk;
  logic [TM_W-1:0]       tm_reload;
  logic                  set_int1, set_int2;
  logic                  underflow;
  logic                  taken;
  int_vec_t              req;

  spr_access u_spr_access (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .spr_req   (spr_req),
    .pb_in     (pb_in),
    .pc_in     (pc_in),
    .rd_data   (rd_data),
    .mk        (mk),
    .tm_reload (tm_reload),
    .pa_out    (pa_out),
    .pb_out    (pb_out),
    .pb_oe     (pb_oe),
    .pc_out    (pc_out),
    .pc_oe     (pc_oe)
  );

  int_sampler u_int_sampler (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .int1        (int1),
    .int2        (int2),
    .int2_rising (mk[MK_INT2_EDGE]),
    .set_int1    (set_int1),
    .set_int2    (set_int2)
  );

  interval_timer u_interval_timer (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .tm_reload (tm_reload),
    .underflow (underflow)
  );

  int_controller u_int_controller (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .int0      (int0),
    .set_int1  (set_int1),
    .set_int2  (set_int2),
    .underflow (underflow),
    .mk        (mk),
    .taken     (taken),
    .req       (req)
  );

  vector_issue u_vector_issue (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .req           (req),
    .credit_return (credit_return),
    .taken         (taken),
    .vec           (vec)
  );

endmodule

`default_nettype wire

/* logic/vector_issue.sv */
`default_nettype none

module vector_issue (
  input  logic               CLK,
  input  logic               rst_n,
  input  intr_pkg::int_vec_t req,
  input  logic               credit_return,
  output logic               taken,
  output intr_pkg::int_vec_t vec
);
  import intr_pkg::*;

  localparam int CRED_W = $clog2(INT_CREDITS + 1);

  logic [CRED_W-1:0] credits;
  logic              refund;

  // No back-to-back issue, the flag clears on the taken edge
  assign taken = req.valid & (credits != '0) & ~vec.valid;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      vec <= '0;
    end else if (taken) begin
      vec <= req;
    end else begin
      vec <= '0;
    end
  end

  // Returns beyond the pool are dropped
  assign refund = credit_return & (credits != CRED_W'(INT_CREDITS));

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CRED_W'(INT_CREDITS);
    end else if (vec.valid & ~credit_return) begin
      credits <= credits - 1'b1;
    end else if (refund & ~vec.valid) begin
      credits <= credits + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/int_controller.sv */
`default_nettype none

module int_controller (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               int0,
  input  logic               set_int1,
  input  logic               set_int2,
  input  logic               underflow,
  input  logic [7:0]         mk,
  input  logic               taken,
  output intr_pkg::int_vec_t req
);
  import intr_pkg::*;

  logic [NUM_SRC-1:0] pend;
  logic [NUM_SRC-1:0] pend_set;
  logic [NUM_SRC-1:0] pend_clr;
  logic [NUM_SRC-1:0] active;

  ////////////////////////////////////////////////////////////
  // Pending flags

  always_comb begin
    pend_set = '0;
    pend_clr = '0;
    // INT0 follows the level
    pend_set[INT_SRC_INT0] = int0 & ~pend[INT_SRC_INT0];
    pend_clr[INT_SRC_INT0] = ~int0;
    pend_set[INT_SRC_INTT] = underflow;
    pend_set[INT_SRC_INT1] = set_int1;
    pend_set[INT_SRC_INT2] = set_int2;
    if (taken) begin
      pend_clr[req.src] = 1'b1;
    end
  end

  // A new event on a flag being taken wins
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~pend_clr) | pend_set;
    end
  end

  ////////////////////////////////////////////////////////////
  // Mask and priority

  // MK bit set masks the source
  assign active = pend & ~mk[NUM_SRC-1:0];

  always_comb begin
    req.valid = |active;
    req.src   = INT_SRC_INT0;
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      if (active[i]) begin
        req.src = int_src_e'(i);
      end
    end
    req.addr = VEC_ADDR[req.src];
  end

endmodule

`default_nettype wire

/* logic/interval_timer.sv */
`default_nettype none

module interval_timer (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic [spr_pkg::TM_W-1:0] tm_reload,
  output logic                     underflow
);
  import spr_pkg::*;
  import intr_pkg::*;

  localparam int CNT_W = TM_W + PRESCALE_W;

  // Low PRESCALE_W bits form the /8 prescaler
  logic [CNT_W-1:0] cnt;

  assign underflow = (cnt == '0);

  // Zero lasts one cycle, so the period is (reload + 1) * 8
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '1;
    end else if (underflow) begin
      cnt <= {tm_reload, {PRESCALE_W{1'b1}}};
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/int_sampler.sv */
`default_nettype none

module int_sampler (
  input  logic CLK,
  input  logic rst_n,
  input  logic int1,
  input  logic int2,
  input  logic int2_rising,
  output logic set_int1,
  output logic set_int2
);
  import intr_pkg::*;

  localparam int DIV_W = $clog2(TICK_DIV);

  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic [3:0]       hist1, hist2;
  logic             int2_pol;

  // Internal /12 tick
  assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
    end
  end

  // Falling INT2 is turned into a rising one
  assign int2_pol = int2 ^ ~int2_rising;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      hist1 <= '0;
      hist2 <= '0;
    end else if (tick) begin
      hist1 <= {hist1[2:0], int1};
      hist2 <= {hist2[2:0], int2_pol};
    end
  end

  // One low then three highs
  assign set_int1 = tick & (hist1 == FILTER_PATTERN);
  assign set_int2 = tick & (hist2 == FILTER_PATTERN);

endmodule

`default_nettype wire

/* logic/spr_access.sv */
`default_nettype none

module spr_access (
  input  logic                               CLK,
  input  logic                               rst_n,
  input  spr_pkg::spr_req_t                  spr_req,
  input  logic [spr_pkg::SPR_DATA_W-1:0]     pb_in,
  input  logic [spr_pkg::SPR_DATA_W-1:0]     pc_in,
  output logic [spr_pkg::SPR_DATA_W-1:0]     rd_data,
  output logic [spr_pkg::SPR_DATA_W-1:0]     mk,
  output logic [spr_pkg::TM_W-1:0]           tm_reload,
  output logic [spr_pkg::SPR_DATA_W-1:0]     pa_out,
  output logic [spr_pkg::SPR_DATA_W-1:0]     pb_out,
  output logic [spr_pkg::SPR_DATA_W-1:0]     pb_oe,
  output logic [spr_pkg::SPR_DATA_W-1:0]     pc_out,
  output logic [spr_pkg::SPR_DATA_W-1:0]     pc_oe
);
  import spr_pkg::*;

  logic [SPR_DATA_W-1:0] pa_q, pb_q, pc_q, mb_q, mc_q;
  logic [TM_W-1:0]       tm_q;
  logic [SPR_DATA_W-1:0] pb_rd, pc_rd;
  logic [SPR_DATA_W-1:0] rd_mux;

  ////////////////////////////////////////////////////////////
  // Register writes

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pa_q <= '0;
      pb_q <= '0;
      pc_q <= '0;
      mk   <= MK_RESET;
      mb_q <= MODE_RESET;
      mc_q <= MODE_RESET;
      tm_q <= '1;
    end else if (spr_req.wr) begin
      case (spr_req.addr)
        SPR_PA:  pa_q <= spr_req.wdata;
        SPR_PB:  pb_q <= spr_req.wdata;
        SPR_PC:  pc_q <= spr_req.wdata;
        SPR_MK:  mk   <= spr_req.wdata;
        SPR_MB:  mb_q <= spr_req.wdata;
        SPR_MC:  mc_q <= spr_req.wdata;
        SPR_TM0: tm_q[7:0] <= spr_req.wdata;
        // Only the low nibble of TM1 exists
        SPR_TM1: tm_q[TM_W-1:8] <= spr_req.wdata[TM_W-9:0];
        default: ;
      endcase
    end
  end

  // Port pins
  assign pa_out = pa_q;
  assign pb_out = pb_q;
  assign pb_oe  = ~mb_q;
  assign pc_oe  = {~mc_q[7], 5'b0, ~mc_q[1:0]} | PC_FIXED_OE;
  // MC bits set on 7..2 hand the pin to its control function
  assign pc_out = pc_q & {mc_q[7:2], ~mc_q[1:0]};

  assign tm_reload = tm_q;

  ////////////////////////////////////////////////////////////
  // Readback

  // Pin for input bits, latch for output bits
  assign pb_rd = (pb_in & ~pb_oe) | (pb_q & pb_oe);
  assign pc_rd = (pc_in & ~pc_oe) | (pc_q & pc_oe);

  always_comb begin
    case (spr_req.addr)
      SPR_PA:  rd_mux = pa_q;
      SPR_PB:  rd_mux = pb_rd;
      SPR_PC:  rd_mux = pc_rd;
      SPR_MK:  rd_mux = mk;
      SPR_MB:  rd_mux = mb_q;
      SPR_MC:  rd_mux = mc_q;
      SPR_TM0: rd_mux = tm_q[7:0];
      SPR_TM1: rd_mux = {4'h0, tm_q[TM_W-1:8]};
      default: rd_mux = '0;
    endcase
  end

  // Held until the next read
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (spr_req.rd) begin
      rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* logic/intr_pkg.sv */
`default_nettype none

package intr_pkg;

  ////////////////////////////////////////////////////////////
  // Interrupt sources

  // Lower index wins
  typedef enum logic [1:0] {
    INT_SRC_INT0 = 2'd0,
    INT_SRC_INTT = 2'd1,
    INT_SRC_INT1 = 2'd2,
    INT_SRC_INT2 = 2'd3
  } int_src_e;

  localparam int NUM_SRC = 4;

  // Vector address per source, indexed by int_src_e
  localparam logic [NUM_SRC-1:0][7:0] VEC_ADDR = {
    8'h20,
    8'h10,
    8'h08,
    8'h04
  };

  typedef struct packed {
    logic     valid;
    int_src_e src;
    logic [7:0] addr;
  } int_vec_t;

  ////////////////////////////////////////////////////////////
  // Sampler and timer constants

  localparam int TICK_DIV = 12;
  // History is shifted in at bit 0, so bit 3 is the oldest sample
  localparam logic [3:0] FILTER_PATTERN = 4'b0111;
  localparam int PRESCALE_W = 3;

  // MK bit 5 set selects a rising INT2
  localparam int MK_INT2_EDGE = 5;

  // Outstanding vectors allowed toward the consumer
  localparam int INT_CREDITS = 2;

endpackage

`default_nettype wire

/* logic/spr_pkg.sv */
`default_nettype none

package spr_pkg;

  ////////////////////////////////////////////////////////////
  // Register map

  // Special-register numbering of the uPD7801
  typedef enum logic [3:0] {
    SPR_PA  = 4'd0,
    SPR_PB  = 4'd1,
    SPR_PC  = 4'd2,
    SPR_MK  = 4'd3,
    SPR_MB  = 4'd4,
    SPR_MC  = 4'd5,
    SPR_TM0 = 4'd6,
    SPR_TM1 = 4'd7
  } spr_addr_e;

  localparam int SPR_DATA_W = 8;
  localparam int TM_W = 12;

  ////////////////////////////////////////////////////////////
  // Reset values and fixed patterns

  // Mode bit set means input
  localparam logic [SPR_DATA_W-1:0] MODE_RESET = 8'hff;
  // Every source masked
  localparam logic [SPR_DATA_W-1:0] MK_RESET = 8'hff;
  // PC6..PC2 are outputs whatever MC holds
  localparam logic [SPR_DATA_W-1:0] PC_FIXED_OE = 8'b0111_1100;

  // One access per cycle, write and read may share it
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    spr_addr_e             addr;
    logic [SPR_DATA_W-1:0] wdata;
  } spr_req_t;

endpackage

`default_nettype wire
